//--- src/barrel_cfg.svh
// Screen geometry, sprite sizes and move rates of the barrel subsystem; include wherever needed.
`ifndef BARREL_CFG_SVH
`define BARREL_CFG_SVH

// Coordinates and sprites.
`define POS_W 11
`define BARREL_SIZE 32
`define DONKEY_W 48
`define DONKEY_H 60

// Platforms: a sloped run drops by OFFSET every WIDTH pixels.
`define PLATFORM_WIDTH 64
`define PLATFORM_OFFSET 2
`define PLATFORM_COUNT 4
`define PLATFORM_Y0 208
`define PLATFORM_PITCH 120
`define PLAT_X_MIN 64
`define PLAT_X_MAX 960

// Clock cycles per motion step.
`define MOVE_DIV 4
`define FALL_DIV 8

`define START_Y `PLATFORM_Y0

`endif

//--- src/barrel_pkg.sv
// Types shared by the barrel RTL and its testbench; import with barrel_pkg::*.
`include "barrel_cfg.svh"

package barrel_pkg;

    localparam int PLAT_IDX_W = $clog2(`PLATFORM_COUNT);

    typedef enum logic [1:0] {
        PLAT_NONE,
        PLAT_LEFT,
        PLAT_RIGHT
    } plat_dir_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_GO_HOR,
        ST_FALL_DOWN
    } barrel_state_t;

    typedef enum logic {
        EV_DONE,
        EV_HIT
    } ev_kind_t;

    typedef struct packed {
        logic [`POS_W-1:0] x;
        logic [`POS_W-1:0] y;
    } pos_t;

    typedef struct packed {
        plat_dir_t               dir;
        logic                    at_end;    // X has reached the downhill edge.
        logic [`POS_W-1:0]       land_y;
        logic [PLAT_IDX_W-1:0]   idx;
    } map_info_t;

    typedef struct packed {
        logic [`POS_W-1:0] x;
    } launch_t;

    typedef struct packed {
        ev_kind_t kind;
        pos_t     pos;
    } barrel_event_t;

endpackage

//--- src/barrel_launcher.sv
// Input side of the barrel subsystem: takes launch requests and offers one start position.
`timescale 1ns/10ps
`include "barrel_cfg.svh"

module barrel_launcher import barrel_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    launch_valid,
    output logic    launch_ready,
    input  launch_t launch,
    output logic    start_valid,
    input  logic    start_ready,
    output pos_t    start_pos
);

    localparam logic [`POS_W-1:0] X_LO = `POS_W'(`PLAT_X_MIN);
    localparam logic [`POS_W-1:0] X_HI = `POS_W'(`PLAT_X_MAX - `BARREL_SIZE);

    logic [`POS_W-1:0] clamp_x;
    logic              take;

    // Keep the barrel sprite fully on the platforms.
    always_comb begin
        if (launch.x < X_LO) begin
            clamp_x = X_LO;
        end else if (launch.x > X_HI) begin
            clamp_x = X_HI;
        end else begin
            clamp_x = launch.x;
        end
    end

    assign launch_ready = !start_valid || start_ready; // Empty, or emptying now.
    assign take = launch_valid && launch_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_valid <= 1'b0;
        end else if (take) begin
            start_valid <= 1'b1;
        end else if (start_ready) begin
            start_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            start_pos.x <= clamp_x;
            start_pos.y <= `POS_W'(`START_Y);
        end
    end

endmodule

//--- src/map_control.sv
// Platform lookup: gives slope direction, landing height and edge flag for a barrel position.
`timescale 1ns/10ps
`include "barrel_cfg.svh"

module map_control import barrel_pkg::*; (
    input  pos_t      pos,
    output map_info_t info
);

    localparam logic [`POS_W-1:0] X_LO = `POS_W'(`PLAT_X_MIN);
    localparam logic [`POS_W-1:0] X_HI = `POS_W'(`PLAT_X_MAX - `BARREL_SIZE);

    // Even platforms slope down to the right, odd ones to the left.
    function automatic plat_dir_t dir_of(input int idx);
        return (idx % 2 == 0) ? PLAT_RIGHT : PLAT_LEFT;
    endfunction

    function automatic logic [`POS_W-1:0] land_of(input int idx, input logic [`POS_W-1:0] x);
        logic [`POS_W-1:0] base;
        logic [`POS_W-1:0] rel;
        base = `POS_W'(`PLATFORM_Y0 + idx * `PLATFORM_PITCH);
        if (x < X_LO || x > X_HI) begin
            rel = '0;
        end else if (dir_of(idx) == PLAT_RIGHT) begin
            rel = x - X_LO;
        end else begin
            rel = X_HI - x;
        end
        // One drop of OFFSET per full run of WIDTH pixels from the uphill end.
        return base + (rel / `POS_W'(`PLATFORM_WIDTH)) * `POS_W'(`PLATFORM_OFFSET);
    endfunction

    always_comb begin
        info.dir    = PLAT_NONE;
        info.at_end = 1'b0;
        info.land_y = pos.y;
        info.idx    = PLAT_IDX_W'(`PLATFORM_COUNT - 1);
        // Walk upward so the highest surface under the barrel wins.
        for (int i = `PLATFORM_COUNT - 1; i >= 0; i--) begin
            if (land_of(i, pos.x) >= pos.y) begin
                info.dir    = dir_of(i);
                info.land_y = land_of(i, pos.x);
                info.idx    = PLAT_IDX_W'(i);
                if (dir_of(i) == PLAT_RIGHT) begin
                    info.at_end = (pos.x >= X_HI);
                end else begin
                    info.at_end = (pos.x <= X_LO);
                end
            end
        end
    end

endmodule

//--- src/hor_barrel.sv
// Barrel motion FSM: rolls along platforms, falls between them, retires on the end or a hit.
`timescale 1ns/10ps
`include "barrel_cfg.svh"

module hor_barrel import barrel_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          start_valid,
    output logic          start_ready,
    input  pos_t          start_pos,
    input  pos_t          donkey_pos,
    output logic          ret_valid,
    output barrel_event_t ret,
    input  logic          busy_out
);

    localparam logic [`POS_W-1:0] X_LO = `POS_W'(`PLAT_X_MIN);
    localparam logic [`POS_W-1:0] X_HI = `POS_W'(`PLAT_X_MAX - `BARREL_SIZE);
    localparam logic [PLAT_IDX_W-1:0] LAST = PLAT_IDX_W'(`PLATFORM_COUNT - 1);

    barrel_state_t     state, state_nxt;
    pos_t              pos, pos_nxt;
    logic [`POS_W-1:0] vel, vel_nxt;
    logic [15:0]       cnt, cnt_nxt;
    logic [`POS_W-1:0] x_step, rel_step;
    logic              retire, hit;
    ev_kind_t          kind;
    map_info_t         info;

    map_control u_map (
        .pos (pos),
        .info(info)
    );

    // Box overlap, one bit wider so the sums cannot wrap.
    assign hit = (state != ST_IDLE)
        && ({1'b0, pos.x} < {1'b0, donkey_pos.x} + (`POS_W+1)'(`DONKEY_W))
        && ({1'b0, donkey_pos.x} < {1'b0, pos.x} + (`POS_W+1)'(`BARREL_SIZE))
        && ({1'b0, pos.y} < {1'b0, donkey_pos.y} + (`POS_W+1)'(`DONKEY_H))
        && ({1'b0, donkey_pos.y} < {1'b0, pos.y} + (`POS_W+1)'(`BARREL_SIZE));

    // No new flight until the previous event has left the reporter.
    assign start_ready = (state == ST_IDLE) && !busy_out && !ret_valid;

    assign x_step   = (info.dir == PLAT_RIGHT) ? pos.x + 1'b1 : pos.x - 1'b1;
    assign rel_step = (info.dir == PLAT_RIGHT) ? x_step - X_LO : X_HI - x_step;

    always_comb begin
        state_nxt = state;
        pos_nxt   = pos;
        vel_nxt   = vel;
        cnt_nxt   = cnt + 1'b1;
        retire    = 1'b0;
        kind      = EV_DONE;
        case (state)
            ST_IDLE: begin
                cnt_nxt = '0;
                if (start_valid && start_ready) begin
                    state_nxt = ST_GO_HOR;
                    pos_nxt   = start_pos;
                    vel_nxt   = '0;
                end
            end
            ST_GO_HOR: begin
                if (hit) begin
                    retire = 1'b1;
                    kind   = EV_HIT;
                end else if (info.dir == PLAT_NONE || (info.at_end && info.idx == LAST)) begin
                    retire = 1'b1;
                end else if (info.at_end || info.land_y > pos.y) begin
                    state_nxt = ST_FALL_DOWN;
                    vel_nxt   = `POS_W'(1);
                    cnt_nxt   = '0;
                    if (info.at_end) begin
                        pos_nxt.y = pos.y + 1'b1; // Leave the surface so the map looks below.
                    end
                end else if (cnt == 16'(`MOVE_DIV - 1)) begin
                    cnt_nxt   = '0;
                    pos_nxt.x = x_step;
                    if (rel_step % `POS_W'(`PLATFORM_WIDTH) == '0) begin
                        pos_nxt.y = pos.y + `POS_W'(`PLATFORM_OFFSET);
                    end
                end
            end
            ST_FALL_DOWN: begin
                if (hit) begin
                    retire = 1'b1;
                    kind   = EV_HIT;
                end else if (info.dir == PLAT_NONE) begin
                    retire = 1'b1;
                end else if (cnt == 16'(`FALL_DIV - 1)) begin
                    cnt_nxt = '0;
                    if (pos.y + vel >= info.land_y) begin
                        pos_nxt.y = info.land_y; // Landed.
                        state_nxt = ST_GO_HOR;
                    end else begin
                        pos_nxt.y = pos.y + vel;
                        vel_nxt   = vel + 1'b1;
                    end
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
        if (retire) begin
            state_nxt = ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            cnt       <= '0;
            vel       <= '0;
            ret_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            cnt       <= cnt_nxt;
            vel       <= vel_nxt;
            ret_valid <= retire;
        end
    end

    always_ff @(posedge clk) begin
        pos <= pos_nxt;
        if (retire) begin
            ret.kind <= kind;
            ret.pos  <= pos;
        end
    end

endmodule

//--- src/barrel_report.sv
// Output side of the barrel subsystem: holds one retirement and offers it on valid/ready.
`timescale 1ns/10ps

module barrel_report import barrel_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          ret_valid,
    input  barrel_event_t ret,
    output logic          busy,
    output logic          ev_valid,
    input  logic          ev_ready,
    output barrel_event_t ev
);

    assign busy = ev_valid;

    // The roller never retires while an event is held, so capture always has room.
    always_ff @(posedge clk) begin
        if (rst) begin
            ev_valid <= 1'b0;
        end else if (ret_valid) begin
            ev_valid <= 1'b1;
        end else if (ev_ready) begin
            ev_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ret_valid) begin
            ev <= ret;
        end
    end

endmodule

//--- src/barrel_top.sv
// Top of the barrel subsystem: launcher feeds the roller, roller feeds the event reporter.
`timescale 1ns/10ps

module barrel_top import barrel_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          launch_valid,
    output logic          launch_ready,
    input  launch_t       launch,
    input  pos_t          donkey_pos,
    output logic          ev_valid,
    input  logic          ev_ready,
    output barrel_event_t ev
);

    logic          start_valid;
    logic          start_ready;
    pos_t          start_pos;
    logic          ret_valid;
    barrel_event_t ret;
    logic          busy;

    barrel_launcher u_launcher (
        .clk, .rst,
        .launch_valid, .launch_ready, .launch,
        .start_valid, .start_ready, .start_pos
    );

    hor_barrel u_barrel (
        .clk, .rst,
        .start_valid, .start_ready, .start_pos,
        .donkey_pos,
        .ret_valid, .ret,
        .busy_out(busy)
    );

    barrel_report u_report (
        .clk, .rst,
        .ret_valid, .ret, .busy,
        .ev_valid, .ev_ready, .ev
    );

endmodule

//--- bench/barrel_checker.sv
// Concurrent assertions on the barrel subsystem, bound into barrel_top by the bind at the end.
`timescale 1ns/10ps
`include "barrel_cfg.svh"

module barrel_checker import barrel_pkg::*; (
    input logic          clk,
    input logic          rst,
    input logic          launch_valid,
    input logic          launch_ready,
    input launch_t       launch,
    input pos_t          donkey_pos,
    input logic          start_valid,
    input logic          start_ready,
    input pos_t          start_pos,
    input logic          ev_valid,
    input logic          ev_ready,
    input barrel_event_t ev,
    input pos_t          roll_pos,
    input barrel_state_t roll_state
);

    localparam int LAST   = `PLATFORM_COUNT - 1;
    localparam int X_HI   = `PLAT_X_MAX - `BARREL_SIZE;
    localparam int DONE_X = (LAST % 2 == 0) ? X_HI : `PLAT_X_MIN; // Downhill edge.
    localparam int DONE_Y = `PLATFORM_Y0 + LAST * `PLATFORM_PITCH
        + ((X_HI - `PLAT_X_MIN) / `PLATFORM_WIDTH) * `PLATFORM_OFFSET;

    int            fail_cnt = 0;
    logic          in_flight;
    int            want_x;
    pos_t          prev_pos;
    barrel_state_t prev_state;

    task automatic report_fail(input string msg);
        $error("%s", msg);
        fail_cnt++;
    endtask

    // Even platforms roll right, odd ones left.
    function automatic int step_x(input pos_t p);
        return (((int'(p.y) - `PLATFORM_Y0) / `PLATFORM_PITCH) % 2 == 0) ? p.x + 1 : p.x - 1;
    endfunction

    function automatic logic overlap(input pos_t b, input pos_t d);
        return int'(b.x) < int'(d.x) + `DONKEY_W && int'(d.x) < int'(b.x) + `BARREL_SIZE
            && int'(b.y) < int'(d.y) + `DONKEY_H && int'(d.y) < int'(b.y) + `BARREL_SIZE;
    endfunction

    always_ff @(posedge clk) begin
        want_x   <= (launch.x < `PLAT_X_MIN) ? `PLAT_X_MIN : (launch.x > X_HI) ? X_HI : launch.x;
        prev_pos <= roll_pos;
        if (rst) begin
            in_flight  <= 1'b0;
            prev_state <= ST_IDLE;
        end else begin
            prev_state <= roll_state;
            if (start_valid && start_ready) begin
                in_flight <= 1'b1;
            end else if (ev_valid && ev_ready) begin
                in_flight <= 1'b0;
            end
        end
    end

    a_reset: assert property (@(posedge clk) $fell(rst) |-> launch_ready && !ev_valid)
        else report_fail("Ready or event valid wrong right after reset");
    a_one_flight: assert property (@(posedge clk) disable iff (rst)
        start_valid && start_ready |-> !in_flight)
        else report_fail("A barrel started before the previous event was taken");
    a_ev_owner: assert property (@(posedge clk) disable iff (rst) $rose(ev_valid) |-> in_flight)
        else report_fail("An event appeared without a barrel in flight");
    a_clamp: assert property (@(posedge clk) disable iff (rst)
        launch_valid && launch_ready |=> start_valid && start_pos.x == want_x
            && start_pos.y == `START_Y)
        else report_fail($sformatf("ERR t=%0t start_pos.x got %0d exp %0d",
            $time, start_pos.x, want_x));
    a_done_x: assert property (@(posedge clk) disable iff (rst)
        $rose(ev_valid) && ev.kind == EV_DONE |-> ev.pos.x == DONE_X)
        else report_fail($sformatf("ERR t=%0t ev.pos.x got %0d exp %0d", $time, ev.pos.x, DONE_X));
    a_done_y: assert property (@(posedge clk) disable iff (rst)
        $rose(ev_valid) && ev.kind == EV_DONE |-> ev.pos.y == DONE_Y)
        else report_fail($sformatf("ERR t=%0t ev.pos.y got %0d exp %0d", $time, ev.pos.y, DONE_Y));
    a_hit: assert property (@(posedge clk) disable iff (rst)
        $rose(ev_valid) && ev.kind == EV_HIT |-> overlap(ev.pos, donkey_pos))
        else report_fail("Hit event at a position clear of the player box");
    a_roll_x: assert property (@(posedge clk) disable iff (rst)
        prev_state == ST_GO_HOR && roll_state == ST_GO_HOR && roll_pos.x != prev_pos.x
            |-> roll_pos.x == step_x(prev_pos))
        else report_fail($sformatf("ERR t=%0t roll_pos.x got %0d exp %0d",
            $time, roll_pos.x, step_x(prev_pos)));
    a_roll_y: assert property (@(posedge clk) disable iff (rst)
        prev_state != ST_IDLE && roll_state != ST_IDLE |-> roll_pos.y >= prev_pos.y)
        else report_fail("Barrel moved upward during a flight");
    a_ev_hold: assert property (@(posedge clk) disable iff (rst)
        ev_valid && !ev_ready |=> ev_valid && $stable(ev))
        else report_fail("Event changed or vanished before it was accepted");
    a_slot_full: assert property (@(posedge clk) disable iff (rst)
        ev_valid && start_valid |-> !start_ready && !launch_ready)
        else report_fail("Launcher kept ready high with its slot full behind a held event");

endmodule

bind barrel_top barrel_checker chk (
    .*,
    .roll_pos  (u_barrel.pos),
    .roll_state(u_barrel.state)
);

//--- bench/barrel_tb.sv
// Testbench for barrel_top: drives launches, the player position and event back-pressure.
`timescale 1ns/10ps
`include "barrel_cfg.svh"

module barrel_tb import barrel_pkg::*; ();

    localparam int   LIMIT  = 40000;                        // Cycles per wait.
    localparam pos_t PARKED = '{x: `POS_W'(2000), y: '0};  // Far off the platforms.

    logic          clk = 1'b0;
    logic          rst = 1'b1;
    logic          launch_valid = 1'b0;
    logic          launch_ready;
    launch_t       launch = '0;
    pos_t          donkey_pos = PARKED;
    logic          ev_valid;
    logic          ev_ready = 1'b1;
    barrel_event_t ev;
    logic          random_ready = 1'b0;
    logic          timed_out = 1'b0;
    int            n_launch = 0;
    int            n_event = 0;
    int            errors = 0;

    barrel_top uut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    task automatic send_launch(input int x);
        int n = 0;
        if (timed_out) return;
        @(negedge clk);
        launch_valid = 1'b1;
        launch.x     = `POS_W'(x);
        while (!launch_ready && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (launch_ready) begin
            n_launch++;
        end else begin
            $display("Timeout: launch_ready stayed low at %0t", $time);
            timed_out = 1'b1;
        end
        @(negedge clk);
        launch_valid = 1'b0;
    endtask

    task automatic hold_event();
        int n = 0;
        if (timed_out) return;
        while (!ev_valid && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!ev_valid) begin
            $display("Timeout: no event raised while ready was held low");
            timed_out = 1'b1;
        end
        repeat (20) @(negedge clk);
    endtask

    task automatic take_event(input ev_kind_t want);
        int n = 0;
        if (timed_out) return;
        do begin
            @(negedge clk);
            ev_ready = random_ready ? 1'($urandom % 2) : 1'b1;
            n++;
        end while (!(ev_valid && ev_ready) && n < LIMIT);
        if (!(ev_valid && ev_ready)) begin
            $display("Timeout: barrel flight produced no event at %0t", $time);
            timed_out = 1'b1;
            return;
        end
        n_event++;
        assert (ev.kind == want) else begin
            $display("ERR t=%0t ev.kind got %s exp %s", $time, ev.kind.name(), want.name());
            errors++;
        end
        @(negedge clk); // Let the transfer edge pass.
    endtask

    initial begin
        void'($urandom(32'hb5ab));
        repeat (3) @(negedge clk);
        rst = 1'b0;
        repeat (2) begin
            send_launch(`PLAT_X_MIN + $urandom % 900);
            take_event(EV_DONE);
        end
        donkey_pos.x = `POS_W'(`PLAT_X_MIN + 40 + $urandom % 700);
        donkey_pos.y = `POS_W'(`PLATFORM_Y0 + `PLATFORM_PITCH - 28); // On platform 1.
        send_launch(`PLAT_X_MIN + $urandom % 600);
        take_event(EV_HIT);
        donkey_pos = PARKED;
        send_launch(5);    // Clamps to the left end.
        take_event(EV_DONE);
        send_launch(1500); // Clamps to the right end.
        take_event(EV_DONE);
        // Hold the first event, fill the launcher slot, then drain at random.
        ev_ready = 1'b0;
        send_launch(300);
        hold_event();
        send_launch(700);
        random_ready = 1'b1;
        fork
            send_launch(2040);
            begin
                take_event(EV_DONE);
                take_event(EV_DONE);
            end
        join
        take_event(EV_DONE);
        if (n_launch != n_event) begin
            $display("Launch and event counts differ");
            errors++;
        end
        errors += uut.chk.fail_cnt;
        $display("launches %0d, events %0d, errors %0d, timeouts %0d",
            n_launch, n_event, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- barrel_sys.f
+incdir+src
src/barrel_pkg.sv
src/barrel_launcher.sv
src/map_control.sv
src/hor_barrel.sv
src/barrel_report.sv
src/barrel_top.sv
bench/barrel_checker.sv
bench/barrel_tb.sv

//--- Bender.yml
package:
  name: barrel_sys

sources:
  - include_dirs:
      - src
    files:
      - src/barrel_pkg.sv
      - src/barrel_launcher.sv
      - src/map_control.sv
      - src/hor_barrel.sv
      - src/barrel_report.sv
      - src/barrel_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/barrel_checker.sv
      - bench/barrel_tb.sv
